// File: hdl/audioPkg.sv
//~~~~~~~~~~~~~~~~~~~~
// audio side definitions
// sample word, slot timing constants,
// buffer sizing and the player status struct
//~~~~~~~~~~~~~~~~~~~~
package audioPkg;

	// sample word
	localparam int SampleBits = 16;                // bits per audio sample
	typedef logic [SampleBits-1:0] sampleT;        // one 16-bit sample

	// slot timing, one LRClk half is one channel slot
	localparam int SlotCycles = 32;                // SClk cycles per LRClk half
	localparam int PopPos = 28;                    // slot position of the pop
	localparam int SlotPosBits = $clog2(SlotCycles);
	typedef logic [SlotPosBits-1:0] slotPosT;      // position inside a slot

	// buffer sizing
	localparam int FifoDepth = 64;                 // words of storage
	localparam int FillTarget = 48;                // refill level
	localparam int FifoAddrBits = $clog2(FifoDepth);
	localparam int FillBits = $clog2(FifoDepth + 1);
	typedef logic [FifoAddrBits-1:0] fifoPtrT;     // circular store index
	typedef logic [FillBits-1:0] fillLevelT;       // 0 .. FifoDepth

	// player status, built at the top level
	typedef struct packed
	{
		logic busy;                                // fetcher reading memory
		logic playing;                             // preload done, output running
		logic underrun;                            // sticky, buffer ran dry
		fillLevelT fillLevel;                      // buffer occupancy
	} playerStatusT;

endpackage

// File: hdl/memPkg.sv
//~~~~~~~~~~~~~~~~~~~~
// sample memory definitions
// address width, first sample address,
// request and response structs
//~~~~~~~~~~~~~~~~~~~~
package memPkg;

	import audioPkg::*;                        // memory returns sample words

	// word addressing
	localparam int AddrBits = 25;              // sample memory address width
	typedef logic [AddrBits-1:0] memAddrT;     // word address
	localparam memAddrT BaseAddr = 25'h80000;  // first sample of the song

	// request, driven by the fetcher
	// rd is a level held with a stable addr until ack comes back
	typedef struct packed
	{
		logic rd;                              // read level
		memAddrT addr;                         // word address, stable while rd
	} memReqT;

	// response, driven by the memory
	typedef struct packed
	{
		logic waitReq;                         // memory not ready, no new start
		logic ack;                             // one cycle, data valid
		sampleT data;                          // read data
	} memRspT;

endpackage

// File: hdl/sampleFetcher.sv
//~~~~~~~~~~~~~~~~~~~~
// sample fetcher
// preload and refill FSM, reads the sample
// memory word by word into the buffer and
// raises playEnable after the preload
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sampleFetcher
	import audioPkg::*, memPkg::*;
(
	input logic SClk,
	input logic reset,
	input logic newFrame,           // top-up request
	input memRspT memRsp,
	input fillLevelT fillLevel,     // buffer occupancy
	output memReqT memReq,
	output logic wrEn,              // one-cycle write strobe
	output sampleT wrData,
	output logic playEnable,        // level, preload complete
	output logic busy               // reading memory
);

	typedef enum logic [2:0]
	{
		Idle,                       // wait for memory after reset
		Fetch,                      // rd held until ack
		Capture,                    // write captured word
		Check,                      // stop address reached?
		Play,                       // wait for newFrame
		RefillWait                  // wait for memory before refill
	} fetchStateT;

	fetchStateT state, nextState;
	memAddrT addr;                  // next word to read
	memAddrT stopAddr, stopAddrNext; // address that ends the current fill
	fillLevelT refillCount;         // words missing to FillTarget

	// words to top up, never negative
	assign refillCount = (fillLevel < fillLevelT'(FillTarget)) ?
		fillLevelT'(FillTarget) - fillLevel : '0;

	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			state <= Idle;
			addr <= BaseAddr;
			stopAddr <= BaseAddr;
			playEnable <= 1'b0;
		end
		else
		begin
			state <= nextState;
			stopAddr <= stopAddrNext;
			if (state == Capture)
				addr <= addr + 1'b1;            // runs on, no wrap
			if (state == Check && addr == stopAddr)
				playEnable <= 1'b1;             // stays set after preload
		end
	end

	// data register, loaded on ack and written next cycle
	always_ff @(posedge SClk)
	begin
		if (state == Fetch && memRsp.ack)
			wrData <= memRsp.data;
	end

	always_comb
	begin
		nextState = state;
		stopAddrNext = stopAddr;
		case (state)
			Idle:
				if (!memRsp.waitReq)
				begin
					nextState = Fetch;
					stopAddrNext = addr + memAddrT'(FillTarget); // full preload
				end
			Fetch:
				if (memRsp.ack)
					nextState = Capture;
			Capture:
				nextState = Check;
			Check:
				if (addr == stopAddr)
					nextState = Play;
				else
					nextState = Fetch;
			Play:
				if (newFrame)
					nextState = RefillWait; // newFrame only seen here
			RefillWait:
				if (!memRsp.waitReq)
				begin
					if (refillCount == '0)
						nextState = Play;   // buffer already at target
					else
						nextState = Fetch;
					stopAddrNext = addr + memAddrT'(refillCount);
				end
			default:
				nextState = Idle;
		endcase
	end

	assign memReq.rd = (state == Fetch);    // rd low in Capture and Check
	assign memReq.addr = addr;
	assign wrEn = (state == Capture);
	assign busy = (state == Fetch) || (state == Capture) || (state == Check);

endmodule

// File: hdl/sampleFifo.sv
//~~~~~~~~~~~~~~~~~~~~
// sample buffer
// circular store with read and write
// pointers, empty flag and fill level
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sampleFifo
	import audioPkg::*;
(
	input logic SClk,
	input logic reset,
	input logic wrEn,               // never asserted when full
	input sampleT wrData,
	input logic rdEn,               // gated with empty by the reader
	output sampleT rdData,          // head word, always visible
	output logic empty,
	output fillLevelT fillLevel
);

	sampleT mem [FifoDepth];        // storage
	fifoPtrT wrPtr;                 // next slot to write
	fifoPtrT rdPtr;                 // head of queue
	fillLevelT count;               // words held

	// storage write
	always_ff @(posedge SClk)
	begin
		if (wrEn)
			mem[wrPtr] <= wrData;
	end

	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;      // wraps at FifoDepth
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			case ({wrEn, rdEn})
				2'b10:
					count <= count + 1'b1;  // write only
				2'b01:
					count <= count - 1'b1;  // read only
				default:
					count <= count;         // both or neither
			endcase
		end
	end

	assign rdData = mem[rdPtr];     // first-word fall-through
	assign empty = (count == '0);
	assign fillLevel = count;

endmodule

// File: hdl/i2sSerializer.sv
//~~~~~~~~~~~~~~~~~~~~
// I2S serializer
// LRClk sync and edge detect, slot position
// counter, late word pop, MSB-first Dout
// and sticky underrun flag
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module i2sSerializer
	import audioPkg::*;
(
	input logic SClk,
	input logic reset,
	input logic LRClk,              // external, asynchronous to slot position
	input logic playEnable,
	input sampleT rdData,           // buffer head word
	input logic empty,
	output logic rdEn,              // one-cycle pop
	output logic Dout,
	output logic underrun           // sticky until reset
);

	typedef enum logic [1:0]
	{
		Stop,                       // waiting for playEnable and LRClk high
		Hold,                       // shifting out, wait for pop position
		Pop                         // take next word
	} serStateT;

	serStateT state, nextState;
	logic [1:0] lrSync;             // two-stage LRClk sync
	logic lrEdge;                   // either edge of synced LRClk
	slotPosT slotPos;               // SClk count inside slot
	sampleT curWord;                // word for the next/current slot
	logic [3:0] bitSel;             // bit of curWord on Dout

	assign lrEdge = lrSync[1] ^ lrSync[0];
	assign bitSel = 4'(SampleBits - 1) - slotPos[3:0];  // MSB first

	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			lrSync <= '0;
			state <= Stop;
			slotPos <= '0;
			curWord <= '0;
			Dout <= 1'b0;
			underrun <= 1'b0;
		end
		else
		begin
			lrSync <= {lrSync[0], LRClk};
			state <= nextState;
			if (lrEdge)
				slotPos <= '0;              // new slot starts
			else
				slotPos <= slotPos + 1'b1;
			// data bits first, zero padding afterwards
			Dout <= (state != Stop) && (slotPos < SampleBits) && curWord[bitSel];
			if (state == Pop)
			begin
				if (empty)
				begin
					curWord <= '0;          // silent slot
					underrun <= 1'b1;
				end
				else
					curWord <= rdData;      // used from next slot start
			end
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			Stop:
				if (playEnable && LRClk)
					nextState = Hold;
			Hold:
				if (!playEnable)
					nextState = Stop;
				else if (slotPos == slotPosT'(PopPos - 1))
					nextState = Pop;        // Pop lands on PopPos
			Pop:
				if (!playEnable)
					nextState = Stop;
				else
					nextState = Hold;
			default:
				nextState = Stop;
		endcase
	end

	assign rdEn = (state == Pop) && !empty;  // no pop from empty buffer

endmodule

// File: hdl/audioPlayer.sv
//~~~~~~~~~~~~~~~~~~~~
// audio player top
// fetcher, sample buffer and serializer,
// plus the status struct
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module audioPlayer
	import audioPkg::*, memPkg::*;
(
	input logic SClk,
	input logic reset,
	input logic LRClk,
	input logic newFrame,
	input memRspT memRsp,
	output memReqT memReq,
	output logic Dout,
	output playerStatusT status
);

	logic wrEn;                     // fetcher -> buffer
	sampleT wrData;
	logic rdEn;                     // serializer -> buffer
	sampleT rdData;
	logic empty;
	fillLevelT fillLevel;
	logic playEnable;               // fetcher -> serializer
	logic busy;
	logic underrun;

	sampleFetcher fetcher_i
	(
		.SClk(SClk),
		.reset(reset),
		.newFrame(newFrame),
		.memRsp(memRsp),
		.fillLevel(fillLevel),
		.memReq(memReq),
		.wrEn(wrEn),
		.wrData(wrData),
		.playEnable(playEnable),
		.busy(busy)
	);

	sampleFifo fifo_i
	(
		.SClk(SClk),
		.reset(reset),
		.wrEn(wrEn),
		.wrData(wrData),
		.rdEn(rdEn),
		.rdData(rdData),
		.empty(empty),
		.fillLevel(fillLevel)
	);

	i2sSerializer serializer_i
	(
		.SClk(SClk),
		.reset(reset),
		.LRClk(LRClk),
		.playEnable(playEnable),
		.rdData(rdData),
		.empty(empty),
		.rdEn(rdEn),
		.Dout(Dout),
		.underrun(underrun)
	);

	// status word, no extra register stage
	assign status.busy = busy;
	assign status.playing = playEnable;
	assign status.underrun = underrun;
	assign status.fillLevel = fillLevel;

endmodule

// File: test/memModel.sv
//~~~~~~~~~~~~~~~~~~~~
// behavioural sample memory
// start-up wait, per-read ack latency with
// optional random jitter, data from address
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module memModel
	import audioPkg::*, memPkg::*;
(
	input logic SClk,
	input logic reset,
	input int waitCycles,           // waitReq high this long after reset
	input int latency,              // rd cycles until ack, 1 or more
	input logic jitter,             // adds 0 or 1 random cycle per read
	input memReqT memReq,
	output memRspT memRsp
);

	int seed = 32'hd79a_b2ef;       // fixed jitter seed
	int waitCnt;                    // start-up wait left
	int lateCnt;                    // rd cycles seen for this read
	int reqLat;                     // latency of the read in progress
	int need;
	logic ack;
	sampleT data;

	always @(posedge SClk)
	begin
		if (reset)
		begin
			waitCnt <= waitCycles;
			lateCnt <= 0;
			reqLat <= 1;
			ack <= 1'b0;
			data <= '0;
		end
		else
		begin
			ack <= 1'b0;                // one-cycle pulse
			if (waitCnt != 0)
				waitCnt <= waitCnt - 1;
			if (memReq.rd && !ack)
			begin
				if (lateCnt == 0)
					need = latency + (jitter ? ($random(seed) & 1) : 0); // new read
				else
					need = reqLat;
				if (lateCnt + 1 >= need)
				begin
					ack <= 1'b1;
					data <= memReq.addr[15:0] ^ 16'h5a3c;   // word from address
					lateCnt <= 0;
				end
				else
				begin
					lateCnt <= lateCnt + 1;
					reqLat <= need;
				end
			end
		end
	end

	assign memRsp = {waitCnt != 0, ack, data};
endmodule

// File: test/audioPlayerTb.sv
//~~~~~~~~~~~~~~~~~~~~
// audio player testbench
// clock and LRClk, test table, memory model,
// address and serial word scoreboard,
// refill and underrun checks, watchdog
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module audioPlayerTb
	import audioPkg::*, memPkg::*;
();

	typedef struct packed
	{
		logic [95:0] name;
		int waitCycles;             // waitReq cycles after reset
		int latency;                // memory ack latency
		logic jitter;
		int frames;                 // newFrame pulses
		int slots;                  // LRClk halves observed
		logic expUnderrun;
	} testRowT;

	localparam int NumTests = 4;
	localparam int ResetCycles = 5;
	localparam int FirstPulse = 20;     // slot of first newFrame
	localparam int PulseGap = 16;       // slots between pulses

	testRowT tests [NumTests] = '{
		'{"fastMem", 0, 1, 1'b0, 4, 96, 1'b0},
		'{"slowMem", 20, 4, 1'b0, 4, 96, 1'b0},
		'{"jitterMem", 7, 2, 1'b1, 4, 96, 1'b0},
		'{"drain", 3, 3, 1'b0, 0, 80, 1'b1}
	};

	logic SClk;
	logic reset;
	logic LRClk;
	logic newFrame;
	memReqT memReq;
	memRspT memRsp;
	logic Dout;
	playerStatusT status;
	int waitCycles;
	int latency;
	logic jitter;
	testRowT curTest;
	int readCount;                      // acks seen this row
	int wordCount;                      // data words heard
	int pulsesDone;
	int levelAtPulse;
	int readsAtPulse;
	int halves;                         // LRClk halves since pulse
	sampleT shiftWord;
	logic prevRd;
	logic prevPlaying;
	logic sawUnderrun;
	logic refillOpen;
	logic sawBusy;

	audioPlayer dut_i (.SClk(SClk), .reset(reset), .LRClk(LRClk), .newFrame(newFrame),
		.memRsp(memRsp), .memReq(memReq), .Dout(Dout), .status(status));

	memModel mem_i (.SClk(SClk), .reset(reset), .waitCycles(waitCycles), .latency(latency),
		.jitter(jitter), .memReq(memReq), .memRsp(memRsp));

	initial
	begin
		SClk = 1'b0;
		forever #2 SClk = ~SClk;        // 4 ns period
	end

	task automatic failRun(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	initial
	begin
		longint limit;
		limit = 1000;
		for (int i = 0; i < NumTests; i++)
			limit += longint'(tests[i].slots * SlotCycles * 4 + (ResetCycles + 10) * 4);
		#(limit);
		failRun($sformatf("watchdog: run still going after %0d ns", limit));
	end

	task automatic applyReset();
		reset = 1'b1;
		LRClk = 1'b0;
		newFrame = 1'b0;
		repeat (ResetCycles)
		begin
			@(negedge SClk);
			assert (!memReq.rd && !status.busy && !status.playing && !status.underrun
				&& !Dout && status.fillLevel == '0)
			else failRun($sformatf("outputs not cleared during reset in %s", curTest.name));
		end
		reset = 1'b0;
		{readCount, wordCount, pulsesDone} = '0;
		{prevRd, prevPlaying, sawUnderrun, refillOpen, sawBusy} = '0;
		shiftWord = '0;
	endtask

	task automatic compareWord();
		memAddrT wordAddr;
		sampleT expWord;
		wordAddr = BaseAddr + memAddrT'(wordCount);
		expWord = wordAddr[15:0] ^ 16'h5a3c;    // memory formula
		if (shiftWord != '0)
		begin
			assert (!sawUnderrun)
			else failRun($sformatf("data after underrun in %s", curTest.name));
			assert (shiftWord == expWord)
			else failRun($sformatf("Mismatch in %s: word %0d expected %h actual %h",
				curTest.name, wordCount, expWord, shiftWord));
			wordCount++;
		end
		else
			assert (wordCount == 0 || curTest.expUnderrun)
			else failRun($sformatf("silent slot during playback in %s", curTest.name));
	endtask

	task automatic sampleOutputs(input int off);
		int minReads;
		assert (status.fillLevel <= FifoDepth)
		else failRun($sformatf("fill level %0d above buffer depth", status.fillLevel));
		if (memReq.rd && !prevRd)
			assert (!memRsp.waitReq) else failRun("read started while memory not ready");
		if (memRsp.ack)
		begin
			assert (memReq.addr == BaseAddr + memAddrT'(readCount))
			else failRun($sformatf("Mismatch in %s: read %0d expected addr %h actual %h",
				curTest.name, readCount, BaseAddr + memAddrT'(readCount), memReq.addr));
			readCount++;
		end
		if (status.playing && !prevPlaying)
			assert (readCount == FillTarget)
			else failRun($sformatf("Mismatch in %s: preload reads expected %0d actual %0d",
				curTest.name, FillTarget, readCount));
		if (refillOpen && status.busy)
			sawBusy = 1'b1;
		else if (refillOpen && sawBusy)
		begin
			minReads = FillTarget - levelAtPulse;
			assert (readCount - readsAtPulse >= minReads
				&& readCount - readsAtPulse <= minReads + halves)
			else failRun($sformatf("Mismatch in %s: refill reads expected %0d+%0d actual %0d",
				curTest.name, minReads, halves, readCount - readsAtPulse));
			refillOpen = 1'b0;
		end
		if (sawUnderrun)
			assert (status.underrun) else failRun("underrun flag dropped before reset");
		sawUnderrun = sawUnderrun | status.underrun;
		if (off >= 3 && off <= 18)
			shiftWord = {shiftWord[14:0], Dout};  // MSB arrives first
		else
			assert (!Dout) else failRun($sformatf("Mismatch in %s: pad bit expected 0 actual 1",
				curTest.name));
		if (off == 19)
			compareWord();
		prevRd = memReq.rd;
		prevPlaying = status.playing;
	endtask

	task automatic sendPulse();
		assert (status.playing && !status.busy && !refillOpen)
		else failRun("newFrame due while fetcher not waiting in play");
		newFrame = 1'b1;
		levelAtPulse = int'(status.fillLevel);
		readsAtPulse = readCount;
		halves = 0;
		sawBusy = 1'b0;
		refillOpen = 1'b1;
		pulsesDone++;
	endtask

	task automatic runTest(input testRowT row);
		int off;
		int slot;
		curTest = row;
		waitCycles = row.waitCycles;
		latency = row.latency;
		jitter = row.jitter;
		applyReset();
		for (int cyc = 0; cyc < row.slots * SlotCycles; cyc++)
		begin
			@(negedge SClk);
			off = cyc % SlotCycles;
			slot = cyc / SlotCycles;
			sampleOutputs(off);         // sample first, then drive
			newFrame = 1'b0;
			if (off == 0)
			begin
				halves++;
				LRClk = ~LRClk;
				if (slot >= FirstPulse && (slot - FirstPulse) % PulseGap == 0
					&& pulsesDone < row.frames)
					sendPulse();
			end
		end
		assert (status.underrun == row.expUnderrun)
		else failRun($sformatf("Mismatch in %s: underrun expected %b actual %b",
			row.name, row.expUnderrun, status.underrun));
		assert (!refillOpen && pulsesDone == row.frames)
		else failRun($sformatf("refill did not complete in %s", row.name));
		if (row.expUnderrun)
			assert (wordCount == readCount)
			else failRun($sformatf("Mismatch in %s: words played expected %0d actual %0d",
				row.name, readCount, wordCount));
		else
			assert (wordCount > FillTarget)
			else failRun($sformatf("only %0d words played in %s", wordCount, row.name));
	endtask

	initial
	begin
		reset = 1'b1;
		LRClk = 1'b0;
		newFrame = 1'b0;
		waitCycles = 0;
		latency = 1;
		jitter = 1'b0;
		for (int t = 0; t < NumTests; t++)
			runTest(tests[t]);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: sim.f
hdl/audioPkg.sv
hdl/memPkg.sv
hdl/sampleFetcher.sv
hdl/sampleFifo.sv
hdl/i2sSerializer.sv
hdl/audioPlayer.sv
test/memModel.sv
test/audioPlayerTb.sv

// File: run.sh
#!/bin/sh
# compile the audio player testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module audioPlayerTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/VaudioPlayerTb 2>&1)
simStatus=$?
echo "$out"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "pass message not found"
exit 1
